//--- vlog.f
+incdir+tests
hdl/mem_pkg.sv
hdl/mem_ifs.sv
hdl/rep_addr_gen.sv
hdl/data_ram.sv
hdl/operand_select.sv
hdl/mem_stage_merge.sv
hdl/mem_stage.sv
tests/tb_mem_stage.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_mem_stage -f vlog.f -Mdir obj_dir

out=$(./obj_dir/Vtb_mem_stage)
echo "$out"

if echo "$out" | grep -qx "TEST OK"; then
    exit 0
fi
exit 1

//--- tests/tb_mem_model.svh
`ifndef TB_MEM_MODEL_SVH
`define TB_MEM_MODEL_SVH

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // random source
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    logic [31:0] lfsr_q = 32'd30;

    // galois form, shifts right
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'hd000_0001;
        end
        return s >> 1;
    endfunction

    // one lfsr step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_q[0]};
            lfsr_q = lfsr_next(lfsr_q);
        end
        return r;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // shadow of the data RAM and expected results
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    mem_pkg::word_t shadow [RAM_WORDS];

    function automatic int ram_index(input mem_pkg::addr_t a);
        return int'((a >> 2) % 32'(RAM_WORDS));
    endfunction

    function automatic mem_pkg::addr_t elem_bytes(input mem_pkg::opsize_e sz);
        return 32'd1 << sz;
    endfunction

    function automatic mem_pkg::addr_t align_down(input mem_pkg::addr_t a,
                                                  input mem_pkg::opsize_e sz);
        return a & ~(elem_bytes(sz) - 32'd1);
    endfunction

    // zero-extended little endian lane of the shadow word
    function automatic mem_pkg::word_t expected_lane(input mem_pkg::addr_t a,
                                                     input mem_pkg::opsize_e sz);
        mem_pkg::word_t w;
        w = shadow[ram_index(a)];
        case (sz)
            mem_pkg::SIZE_BYTE: return (w >> {a[1:0], 3'b000}) & 32'h0000_00ff;
            mem_pkg::SIZE_HALF: return (w >> {a[1], 4'b0000}) & 32'h0000_ffff;
            default:            return w;
        endcase
    endfunction

`endif

//--- tests/tb_mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_stage;

    localparam int RAM_WORDS = 64;

    typedef struct packed {
        logic [31:0] data;
        logic [31:0] addr;
        logic        last;
        logic [31:0] due;
    } exp_t;

    logic                 clk, rst_n, valid, is_rep, dir_dec, wb_valid;
    mem_pkg::count_t      count;
    mem_pkg::addr_t       addr, wb_addr, res_addr;
    mem_pkg::opsize_e     size;
    mem_pkg::addend_src_e addend_src;
    mem_pkg::word_t       imm, wb_data, res;
    mem_pkg::word_t       regs [4];
    logic                 busy, res_valid, res_last;

    // expected results, filled by the stimulus and consumed by the checker
    exp_t        exp_mem [256];
    exp_t        head;
    logic [7:0]  wr_ptr = '0;
    logic [7:0]  rd_ptr = '0;
    logic [31:0] cyc = '0;
    logic [31:0] busy_from = 32'd1;
    logic [31:0] busy_to = '0;
    logic        chk_en = 1'b0;
    logic        late, exp_busy;
    int          errors = 0, checks = 0, timeouts = 0, tests = 0, failed = 0;
    int          err_mark, tmo_mark;

    `include "tb_mem_model.svh"

    mem_stage #(
        .RAM_WORDS (RAM_WORDS)
    ) dut0 (
        .clk_i          (clk),
        .rst_n_i        (rst_n),
        .valid_i        (valid),
        .is_rep_i       (is_rep),
        .count_i        (count),
        .addr_i         (addr),
        .size_i         (size),
        .dir_dec_i      (dir_dec),
        .addend_src_i   (addend_src),
        .reg0_i         (regs[0]),
        .reg1_i         (regs[1]),
        .reg2_i         (regs[2]),
        .reg3_i         (regs[3]),
        .imm_i          (imm),
        .wb_valid_i     (wb_valid),
        .wb_addr_i      (wb_addr),
        .wb_data_i      (wb_data),
        .busy_o         (busy),
        .result_valid_o (res_valid),
        .result_o       (res),
        .result_addr_o  (res_addr),
        .result_last_o  (res_last)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 32'd1;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checker, samples at the falling edge
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always @(negedge clk) begin
        if (chk_en) begin
            exp_busy = (cyc >= busy_from) && (cyc <= busy_to);
            checks++;
            assert (busy == exp_busy) else begin
                errors++;
                $display("Error at %0t: busy_o is %b, expected %b", $time, busy, exp_busy);
            end
            late = (rd_ptr != wr_ptr) && (exp_mem[rd_ptr].due < cyc);
            assert (!late) else begin
                errors++;
                $display("Error at %0t: result for addr %h due in cycle %0d is missing",
                         $time, exp_mem[rd_ptr].addr, exp_mem[rd_ptr].due);
                rd_ptr = rd_ptr + 8'd1;
            end
            if (res_valid) begin
                checks++;
                assert (rd_ptr != wr_ptr) else begin
                    errors++;
                    $display("Error at %0t: unexpected result %h at addr %h",
                             $time, res, res_addr);
                end
                if (rd_ptr != wr_ptr) begin
                    head = exp_mem[rd_ptr];
                    rd_ptr = rd_ptr + 8'd1;
                    assert (head.due == cyc && res == head.data && res_addr == head.addr
                            && res_last == head.last) else begin
                        errors++;
                        $display("Error at %0t: got %h addr %h last %b cycle %0d, %s %h %h %b %0d",
                                 $time, res, res_addr, res_last, cyc, "expected",
                                 head.data, head.addr, head.last, head.due);
                    end
                end
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic open_test();
        err_mark = errors;
        tmo_mark = timeouts;
    endtask

    task automatic close_test(input string name);
        tests++;
        if (errors != err_mark || timeouts != tmo_mark) begin
            failed++;
            $display("test %0d, %s: fail", tests, name);
        end else begin
            $display("test %0d, %s: pass", tests, name);
        end
    endtask

    task automatic write_word(input mem_pkg::addr_t a, input mem_pkg::word_t d);
        @(posedge clk);
        #2;
        wb_valid = 1'b1;
        wb_addr = a;
        wb_data = d;
        shadow[ram_index(a)] = d;
        @(posedge clk);
        #2;
        wb_valid = 1'b0;
    endtask

    // one instruction strobe, expectations queued from the step rule
    task automatic issue_load(input logic rep, input mem_pkg::count_t cnt,
                              input mem_pkg::addr_t a, input mem_pkg::opsize_e sz,
                              input logic dir, input mem_pkg::addend_src_e src,
                              input mem_pkg::word_t imm_v);
        mem_pkg::count_t n;
        mem_pkg::word_t  addend;
        mem_pkg::addr_t  ea;
        logic [31:0]     t0;
        exp_t            e;
        n = rep ? cnt : 32'd1;
        addend = (src == mem_pkg::SRC_IMM) ? imm_v : regs[src[1:0]];
        @(posedge clk);
        #2;
        valid = 1'b1;
        is_rep = rep;
        count = cnt;
        addr = a;
        size = sz;
        dir_dec = dir;
        addend_src = src;
        imm = imm_v;
        t0 = cyc;
        for (mem_pkg::count_t k = 0; k < n; k++) begin
            if (dir) begin
                ea = align_down(a, sz) - k * elem_bytes(sz);
            end else begin
                ea = align_down(a, sz) + k * elem_bytes(sz);
            end
            e.data = expected_lane(ea, sz) + addend;
            e.addr = ea;
            e.last = (k == n - 32'd1);
            e.due = t0 + 32'd3 + k;
            exp_mem[wr_ptr] = e;
            wr_ptr = wr_ptr + 8'd1;
        end
        if (n != 0) begin
            busy_from = t0 + 32'd1;
            busy_to = t0 + n;
        end
        @(posedge clk);
        #2;
        valid = 1'b0;
    endtask

    task automatic drain_results(input string what);
        int tries;
        tries = 0;
        while (rd_ptr != wr_ptr && tries < 40) begin
            @(posedge clk);
            tries++;
        end
        if (rd_ptr != wr_ptr) begin
            timeouts++;
            $display("timeout: results of %s never arrived", what);
        end
    endtask

    task automatic wait_busy();
        int tries;
        tries = 0;
        while (!busy && tries < 20) begin
            @(negedge clk);
            tries++;
        end
        if (!busy) begin
            timeouts++;
            $display("timeout: busy_o never went high");
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // test sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        rst_n = 1'b0;
        valid = 1'b0;
        is_rep = 1'b0;
        count = '0;
        addr = '0;
        size = mem_pkg::SIZE_BYTE;
        dir_dec = 1'b0;
        addend_src = mem_pkg::SRC_REG0;
        imm = '0;
        wb_valid = 1'b0;
        wb_addr = '0;
        wb_data = '0;
        for (int i = 0; i < 4; i++) begin
            regs[i] = rand_bits(32);
        end
        repeat (16) @(posedge clk);
        #2;
        rst_n = 1'b1;
        chk_en = 1'b1;

        // nothing driven yet, the checker expects idle outputs
        open_test();
        repeat (3) @(posedge clk);
        close_test("idle after reset");

        for (int i = 0; i < RAM_WORDS; i++) begin
            write_word(32'(i * 4), rand_bits(32));
        end

        open_test();
        for (int s = 0; s < 3; s++) begin
            for (int o = 0; o < 4; o++) begin
                issue_load(1'b0, 32'd7, 32'h0000_0040 + 32'(s * 16 + o),
                           mem_pkg::opsize_e'(s[1:0]), 1'b0, mem_pkg::SRC_IMM, rand_bits(32));
                drain_results("lane load");
            end
        end
        close_test("single loads");

        open_test();
        issue_load(1'b1, 32'd6, 32'h0000_0081, mem_pkg::SIZE_BYTE, 1'b0, mem_pkg::SRC_REG1, '0);
        drain_results("repeat up");
        issue_load(1'b1, 32'd5, 32'h0000_00a7, mem_pkg::SIZE_HALF, 1'b1, mem_pkg::SRC_REG2, '0);
        drain_results("repeat down");
        issue_load(1'b1, 32'd3, 32'h0000_0012, mem_pkg::SIZE_WORD, 1'b1, mem_pkg::SRC_REG0, '0);
        drain_results("repeat word down");
        close_test("repeat stepping");

        open_test();
        issue_load(1'b1, 32'd0, 32'h0000_0020, mem_pkg::SIZE_WORD, 1'b0, mem_pkg::SRC_IMM, '1);
        repeat (8) @(posedge clk);
        close_test("repeat count zero");

        open_test();
        issue_load(1'b1, 32'd6, 32'h0000_0030, mem_pkg::SIZE_WORD, 1'b0, mem_pkg::SRC_IMM,
                   rand_bits(32));
        wait_busy();
        // second strobe lands while the sequencer runs
        @(posedge clk);
        #2;
        valid = 1'b1;
        count = 32'd9;
        imm = ~imm;
        @(posedge clk);
        #2;
        valid = 1'b0;
        drain_results("busy strobe");
        close_test("strobe while busy");

        open_test();
        write_word(mem_pkg::addr_t'(RAM_WORDS * 20) + 32'h24, rand_bits(32));
        issue_load(1'b0, 32'd0, 32'h0000_0024, mem_pkg::SIZE_WORD, 1'b0, mem_pkg::SRC_REG3, '0);
        drain_results("written word");
        issue_load(1'b0, 32'd0, 32'h8000_0026, mem_pkg::SIZE_BYTE, 1'b0, mem_pkg::SRC_IMM,
                   rand_bits(32));
        drain_results("wrapped byte");
        close_test("writeback and wrap");

        $display("%0d tests, %0d failed, %0d checks, %0d errors, %0d timeouts",
                 tests, failed, checks, errors, timeouts);
        if (errors == 0 && timeouts == 0 && failed == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hdl/mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage #(
    parameter int RAM_WORDS = 256
) (
    input  wire                       clk_i,
    input  wire                       rst_n_i,

    // instruction strobe
    input  wire                       valid_i,
    input  wire                       is_rep_i,
    input  wire mem_pkg::count_t      count_i,
    input  wire mem_pkg::addr_t       addr_i,
    input  wire mem_pkg::opsize_e     size_i,
    input  wire                       dir_dec_i,
    input  wire mem_pkg::addend_src_e addend_src_i,
    input  wire mem_pkg::word_t       reg0_i,
    input  wire mem_pkg::word_t       reg1_i,
    input  wire mem_pkg::word_t       reg2_i,
    input  wire mem_pkg::word_t       reg3_i,
    input  wire mem_pkg::word_t       imm_i,

    // writeback
    input  wire                       wb_valid_i,
    input  wire mem_pkg::addr_t       wb_addr_i,
    input  wire mem_pkg::word_t       wb_data_i,

    output logic                      busy_o,
    output logic                      result_valid_o,
    output mem_pkg::word_t            result_o,
    output mem_pkg::addr_t            result_addr_o,
    output logic                      result_last_o
);

    mem_pkg::word_t addend;

    mem_req_if req_bus ();
    mem_rsp_if rsp_bus ();

    // address and RAM path
    rep_addr_gen u_gen (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .valid_i   (valid_i),
        .is_rep_i  (is_rep_i),
        .count_i   (count_i),
        .addr_i    (addr_i),
        .size_i    (size_i),
        .dir_dec_i (dir_dec_i),
        .busy_o    (busy_o),
        .req       (req_bus.gen)
    );

    data_ram #(
        .RAM_WORDS (RAM_WORDS)
    ) u_ram (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .req        (req_bus.ram),
        .wb_valid_i (wb_valid_i),
        .wb_addr_i  (wb_addr_i),
        .wb_data_i  (wb_data_i),
        .rsp        (rsp_bus.ram)
    );

    // operand path, gated by the sequencer busy flag
    operand_select u_opsel (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .valid_i      (valid_i),
        .busy_i       (busy_o),
        .addend_src_i (addend_src_i),
        .reg0_i       (reg0_i),
        .reg1_i       (reg1_i),
        .reg2_i       (reg2_i),
        .reg3_i       (reg3_i),
        .imm_i        (imm_i),
        .addend_o     (addend)
    );

    mem_stage_merge u_merge (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .rsp            (rsp_bus.merge),
        .addend_i       (addend),
        .result_valid_o (result_valid_o),
        .result_o       (result_o),
        .result_addr_o  (result_addr_o),
        .result_last_o  (result_last_o)
    );

endmodule

`default_nettype wire

//--- hdl/mem_stage_merge.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage_merge (
    input  wire                 clk_i,
    input  wire                 rst_n_i,
    mem_rsp_if.merge            rsp,
    input  wire mem_pkg::word_t addend_i,
    output logic                result_valid_o,
    output mem_pkg::word_t      result_o,
    output mem_pkg::addr_t      result_addr_o,
    output logic                result_last_o
);

    mem_pkg::word_t lane;
    mem_pkg::word_t sum;

    logic [7:0]     byte_lane;
    logic [15:0]    half_lane;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // lane extraction, little endian
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign byte_lane = rsp.rsp_data[{rsp.rsp_addr[1:0], 3'b000} +: 8];
    assign half_lane = rsp.rsp_data[{rsp.rsp_addr[1], 4'b0000} +: 16];

    always_comb begin
        case (rsp.rsp_size)
            mem_pkg::SIZE_BYTE: lane = {24'h00_0000, byte_lane};
            mem_pkg::SIZE_HALF: lane = {16'h0000, half_lane};
            default:            lane = rsp.rsp_data;
        endcase
    end

    // wraps modulo 2^32
    assign sum = lane + addend_i;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // result register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            result_valid_o <= 1'b0;
            result_last_o  <= 1'b0;
        end else begin
            result_valid_o <= rsp.rsp_valid;
            result_last_o  <= rsp.rsp_valid && rsp.rsp_last;
        end
    end

    always_ff @(posedge clk_i) begin
        result_o      <= sum;
        result_addr_o <= rsp.rsp_addr;
    end

endmodule

`default_nettype wire

//--- hdl/operand_select.sv
`timescale 1ns/1ps
`default_nettype none

module operand_select (
    input  wire                      clk_i,
    input  wire                      rst_n_i,
    input  wire                      valid_i,
    input  wire                      busy_i,
    input  wire mem_pkg::addend_src_e addend_src_i,
    input  wire mem_pkg::word_t      reg0_i,
    input  wire mem_pkg::word_t      reg1_i,
    input  wire mem_pkg::word_t      reg2_i,
    input  wire mem_pkg::word_t      reg3_i,
    input  wire mem_pkg::word_t      imm_i,
    output mem_pkg::word_t           addend_o
);

    mem_pkg::word_t    regs [4];
    mem_pkg::reg_idx_t reg_idx;
    mem_pkg::word_t    sel_val;
    mem_pkg::word_t    addend_q;

    assign regs[0] = reg0_i;
    assign regs[1] = reg1_i;
    assign regs[2] = reg2_i;
    assign regs[3] = reg3_i;

    assign reg_idx = mem_pkg::reg_idx_t'(addend_src_i[1:0]);

    always_comb begin
        if (addend_src_i == mem_pkg::SRC_IMM) begin
            sel_val = imm_i;
        end else begin
            sel_val = regs[reg_idx];
        end
    end

    // held for all elements of the instruction
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            addend_q <= '0;
        end else if (valid_i && !busy_i) begin
            addend_q <= sel_val;
        end
    end

    assign addend_o = addend_q;

endmodule

`default_nettype wire

//--- hdl/data_ram.sv
`timescale 1ns/1ps
`default_nettype none

module data_ram #(
    parameter int RAM_WORDS = 256
) (
    input  wire                 clk_i,
    input  wire                 rst_n_i,
    mem_req_if.ram              req,
    input  wire                 wb_valid_i,
    input  wire mem_pkg::addr_t wb_addr_i,
    input  wire mem_pkg::word_t wb_data_i,
    mem_rsp_if.ram              rsp
);

    localparam int IDX_W = $clog2(RAM_WORDS);

    mem_pkg::word_t   mem [RAM_WORDS];

    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] wr_idx;

    // word address modulo the array depth
    assign rd_idx = req.req_addr[IDX_W+1:2];
    assign wr_idx = wb_addr_i[IDX_W+1:2];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rsp.rsp_valid <= 1'b0;
        end else begin
            rsp.rsp_valid <= req.req_valid;
        end
    end

    // element fields ride along with the read word
    always_ff @(posedge clk_i) begin
        rsp.rsp_addr <= req.req_addr;
        rsp.rsp_size <= req.req_size;
        rsp.rsp_last <= req.req_last;
        // old data on a same-word read and write
        rsp.rsp_data <= mem[rd_idx];
        if (wb_valid_i) begin
            mem[wr_idx] <= wb_data_i;
        end
    end

endmodule

`default_nettype wire

//--- hdl/rep_addr_gen.sv
`timescale 1ns/1ps
`default_nettype none

module rep_addr_gen (
    input  wire              clk_i,
    input  wire              rst_n_i,
    input  wire              valid_i,
    input  wire              is_rep_i,
    input  wire mem_pkg::count_t  count_i,
    input  wire mem_pkg::addr_t   addr_i,
    input  wire mem_pkg::opsize_e size_i,
    input  wire              dir_dec_i,
    output logic             busy_o,
    mem_req_if.gen           req
);

    mem_pkg::gen_state_e state_q;
    mem_pkg::count_t     remain_q;
    mem_pkg::addr_t      addr_q;
    mem_pkg::opsize_e    size_q;
    logic                dir_q;

    logic                accept;
    mem_pkg::count_t     num_elems;
    mem_pkg::addr_t      start_addr;
    mem_pkg::addr_t      step;
    mem_pkg::addr_t      next_addr;

    function automatic logic [2:0] size_bytes(input mem_pkg::opsize_e s);
        case (s)
            mem_pkg::SIZE_BYTE: size_bytes = 3'd1;
            mem_pkg::SIZE_HALF: size_bytes = 3'd2;
            default:            size_bytes = 3'd4;
        endcase
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // instruction accept
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign accept    = valid_i && (state_q == mem_pkg::GEN_IDLE);
    assign num_elems = is_rep_i ? count_i : mem_pkg::count_t'(1);

    // align down to the element size
    assign start_addr = addr_i & ~mem_pkg::addr_t'(size_bytes(size_i) - 3'd1);

    assign step      = mem_pkg::addr_t'(size_bytes(size_q));
    assign next_addr = dir_q ? (addr_q - step) : (addr_q + step);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q  <= mem_pkg::GEN_IDLE;
            remain_q <= '0;
        end else begin
            case (state_q)
                mem_pkg::GEN_IDLE: begin
                    // a repeat with count 0 never leaves idle
                    if (accept && (num_elems != '0)) begin
                        state_q  <= mem_pkg::GEN_RUN;
                        remain_q <= num_elems;
                    end
                end
                mem_pkg::GEN_RUN: begin
                    remain_q <= remain_q - mem_pkg::count_t'(1);
                    if (remain_q == mem_pkg::count_t'(1)) begin
                        state_q <= mem_pkg::GEN_IDLE;
                    end
                end
                default: state_q <= mem_pkg::GEN_IDLE;
            endcase
        end
    end

    // address, size and direction of the running instruction
    always_ff @(posedge clk_i) begin
        if (accept) begin
            addr_q <= start_addr;
            size_q <= size_i;
            dir_q  <= dir_dec_i;
        end else if (state_q == mem_pkg::GEN_RUN) begin
            addr_q <= next_addr;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // request side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign busy_o        = (state_q == mem_pkg::GEN_RUN);
    assign req.req_valid = (state_q == mem_pkg::GEN_RUN);
    assign req.req_addr  = addr_q;
    assign req.req_size  = size_q;
    assign req.req_last  = (remain_q == mem_pkg::count_t'(1));

endmodule

`default_nettype wire

//--- hdl/mem_ifs.sv
`timescale 1ns/1ps
`default_nettype none

// one element request per cycle, no back-pressure
interface mem_req_if;

    logic             req_valid;
    mem_pkg::addr_t   req_addr;
    mem_pkg::opsize_e req_size;
    logic             req_last;

    modport gen (
        output req_valid, req_addr, req_size, req_last
    );

    modport ram (
        input  req_valid, req_addr, req_size, req_last
    );

endinterface

// response lags its request by exactly one cycle
interface mem_rsp_if;

    logic             rsp_valid;
    mem_pkg::addr_t   rsp_addr;
    mem_pkg::opsize_e rsp_size;
    logic             rsp_last;
    mem_pkg::word_t   rsp_data;

    modport ram (
        output rsp_valid, rsp_addr, rsp_size, rsp_last, rsp_data
    );

    modport merge (
        input  rsp_valid, rsp_addr, rsp_size, rsp_last, rsp_data
    );

endinterface

`default_nettype wire

//--- hdl/mem_pkg.sv
`default_nettype none

package mem_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // data path widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // byte address
    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    // remaining elements of a repeat instruction
    typedef logic [31:0] count_t;
    typedef logic [1:0]  reg_idx_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // encodings
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } opsize_e;

    // low two bits of a register source double as the register index
    typedef enum logic [2:0] {
        SRC_REG0 = 3'd0,
        SRC_REG1 = 3'd1,
        SRC_REG2 = 3'd2,
        SRC_REG3 = 3'd3,
        SRC_IMM  = 3'd4
    } addend_src_e;

    typedef enum logic [1:0] {
        GEN_IDLE = 2'd0,
        GEN_RUN  = 2'd1
    } gen_state_e;

endpackage

`default_nettype wire
